// ==== Makefile ====
TOP = tb_intra4x4

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f vlog.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// ==== intra4x4_controller.sv ====
module intra4x4_controller
(
    input  logic       CLK,
    input  logic       rst_0,
    input  logic       in_strobe,
    input  logic       out_ready,
    output logic       in_ready,
    output logic       capture,
    output logic [1:0] rd_index,
    output logic       lane_clear,
    output logic       lane_acc_en,
    output logic       decide,
    output logic       mode_strobe,
    output logic       out_strobe
);

    import intra4x4_pkg::*;

    typedef enum logic [2:0] {
        st_load,
        st_eval,
        st_drain,
        st_wait,
        st_out,
        st_flush
    } state_e;

    state_e     state;
    logic [1:0] in_cnt;
    logic [1:0] rd_cnt;
    logic       strobe_ok;
    logic       rd_eval;
    logic       rd_last;
    logic [2:0] acc_pipe;
    logic [3:0] dec_pipe;
    logic       os_d1;

    assign in_ready  = (state == st_load);
    assign strobe_ok = in_strobe && in_ready;
    assign capture   = strobe_ok && (in_cnt == 2'd0);
    // clear the lanes as the last row goes in
    assign lane_clear = strobe_ok && (in_cnt == 2'(ROWS - 1));

    assign rd_index = rd_cnt;
    assign rd_eval  = (state == st_eval);
    assign rd_last  = rd_eval && (rd_cnt == 2'(ROWS - 1));

    // accumulate lands three cycles after the read
    assign lane_acc_en = acc_pipe[2];
    assign decide      = dec_pipe[3];

    always_ff @(posedge CLK)
    begin
        if (rst_0)
        begin
            state  <= st_load;
            in_cnt <= '0;
            rd_cnt <= '0;
        end
        else
        begin
            case (state)
                st_load:
                begin
                    if (strobe_ok)
                    begin
                        in_cnt <= in_cnt + 2'd1;
                        if (in_cnt == 2'(ROWS - 1))
                            state <= st_eval;
                    end
                end
                st_eval:
                begin
                    rd_cnt <= rd_cnt + 2'd1;
                    if (rd_cnt == 2'(ROWS - 1))
                        state <= st_drain;
                end
                st_drain:
                begin
                    if (mode_strobe)
                        state <= st_wait;
                end
                st_wait:
                begin
                    if (out_ready)
                        state <= st_out;
                end
                st_out:
                begin
                    // the replay always runs to the end
                    rd_cnt <= rd_cnt + 2'd1;
                    if (rd_cnt == 2'(ROWS - 1))
                        state <= st_flush;
                end
                st_flush:
                begin
                    // last out_strobe is on this cycle
                    if (!os_d1)
                        state <= st_load;
                end
                default: state <= st_load;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rst_0)
        begin
            acc_pipe    <= '0;
            dec_pipe    <= '0;
            mode_strobe <= 1'b0;
            os_d1       <= 1'b0;
            out_strobe  <= 1'b0;
        end
        else
        begin
            acc_pipe    <= {acc_pipe[1:0], rd_eval};
            dec_pipe    <= {dec_pipe[2:0], rd_last};
            mode_strobe <= decide;
            // out_word follows the read by two cycles
            os_d1       <= (state == st_out);
            out_strobe  <= os_d1;
        end
    end

endmodule

// ==== intra4x4_mode_select.sv ====
module intra4x4_mode_select
#(
    parameter int SAD_W = 12
)
(
    input  logic                      CLK,
    input  logic                      rst_0,
    input  logic                      decide,
    input  logic                      top_valid,
    input  logic                      left_valid,
    input  logic [SAD_W-1:0]          sad_v,
    input  logic [SAD_W-1:0]          sad_h,
    input  logic [SAD_W-1:0]          sad_dc,
    output intra4x4_pkg::pred_mode_e  mode
);

    import intra4x4_pkg::*;

    pred_mode_e       best_mode;
    logic [SAD_W-1:0] best_sad;

    // dc is always allowed
    // later <= compares let v beat h and h beat dc on a tie
    always_comb
    begin
        best_mode = mode_dc;
        best_sad  = sad_dc;
        if (left_valid && (sad_h <= best_sad))
        begin
            best_mode = mode_horizontal;
            best_sad  = sad_h;
        end
        if (top_valid && (sad_v <= best_sad))
        begin
            best_mode = mode_vertical;
            best_sad  = sad_v;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (rst_0)
            mode <= mode_vertical;
        else if (decide)
            mode <= best_mode;
    end

endmodule

// ==== intra4x4_neighbor_unit.sv ====
module intra4x4_neighbor_unit
(
    input  logic                     CLK,
    input  logic                     rst_0,
    input  logic                     capture,
    input  intra4x4_pkg::neighbor_t  nbr,
    output intra4x4_pkg::neighbor_t  nbr_q,
    output intra4x4_pkg::pixel_t     dc_value
);

    import intra4x4_pkg::*;

    logic [9:0]  sum_top;
    logic [9:0]  sum_left;
    logic [10:0] dc_sum;

    always_ff @(posedge CLK)
    begin
        if (rst_0)
            nbr_q <= '0;
        else if (capture)
            nbr_q <= nbr;
    end

    always_comb
    begin
        sum_top  = {2'b00, nbr_q.top[0]} + {2'b00, nbr_q.top[1]}
                 + {2'b00, nbr_q.top[2]} + {2'b00, nbr_q.top[3]};
        sum_left = {2'b00, nbr_q.left[0]} + {2'b00, nbr_q.left[1]}
                 + {2'b00, nbr_q.left[2]} + {2'b00, nbr_q.left[3]};

        // rounding adds 4 before the divide by 8
        case ({nbr_q.top_valid, nbr_q.left_valid})
            2'b11:   dc_sum = {1'b0, sum_top} + {1'b0, sum_left} + 11'd4;
            2'b10:   dc_sum = {sum_top, 1'b0} + 11'd4;
            2'b01:   dc_sum = {sum_left, 1'b0} + 11'd4;
            default: dc_sum = {DC_DEFAULT, 3'b000};
        endcase
    end

    // ready one cycle after the neighbors are latched
    always_ff @(posedge CLK)
    begin
        dc_value <= dc_sum[10:3];
    end

endmodule

// ==== intra4x4_pkg.sv ====
package intra4x4_pkg;

    // one luma sample
    typedef logic [7:0] pixel_t;

    // four samples with pixel 0 in the low byte
    typedef pixel_t [3:0] row_t;

    // pixel minus prediction in two's complement
    typedef logic signed [8:0] resid_t;

    // residual 0 in the low bits
    typedef resid_t [3:0] resid_row_t;

    typedef enum logic [3:0] {
        mode_vertical   = 4'd0,
        mode_horizontal = 4'd1,
        mode_dc         = 4'd2
    } pred_mode_e;

    // left pixel r sits in byte r of left
    typedef struct packed {
        row_t top;
        row_t left;
        logic top_valid;
        logic left_valid;
    } neighbor_t;

    typedef struct packed {
        resid_row_t resid;
        row_t       base;
    } out_word_t;

    localparam int ROWS = 4;

    // dc value when neither neighbor exists
    localparam pixel_t DC_DEFAULT = 8'd128;

endpackage

// ==== intra4x4_row_buffer.sv ====
module intra4x4_row_buffer
(
    input  logic                CLK,
    input  logic                rst_0,
    input  logic                in_strobe,
    input  intra4x4_pkg::row_t  in_row,
    input  logic [1:0]          rd_index,
    output intra4x4_pkg::row_t  rd_row
);

    import intra4x4_pkg::*;

    row_t       rows [ROWS];
    logic [1:0] wr_ptr;

    // write pointer wraps after the last row
    always_ff @(posedge CLK)
    begin
        if (rst_0)
            wr_ptr <= '0;
        else if (in_strobe)
            wr_ptr <= wr_ptr + 2'd1;
    end

    always_ff @(posedge CLK)
    begin
        if (in_strobe)
            rows[wr_ptr] <= in_row;
        // registered read one cycle behind rd_index
        rd_row <= rows[rd_index];
    end

endmodule

// ==== intra4x4_sad_lane.sv ====
module intra4x4_sad_lane
#(
    parameter int SAD_W = 12
)
(
    input  logic                      CLK,
    input  logic                      rst_0,
    input  intra4x4_pkg::row_t        pixels,
    input  intra4x4_pkg::row_t        pred,
    input  logic                      clear,
    input  logic                      acc_en,
    output intra4x4_pkg::resid_row_t  resid,
    output logic [SAD_W-1:0]          sad
);

    import intra4x4_pkg::*;

    logic [3:0][7:0] abs_q;
    logic [9:0]      abs_sum;

    // first stage differences double as the residual output
    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < 4; i++)
        begin
            resid[i] <= resid_t'({1'b0, pixels[i]} - {1'b0, pred[i]});
        end
    end

    // second stage magnitudes
    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (resid[i][8])
                abs_q[i] <= 8'h00 - resid[i][7:0];
            else
                abs_q[i] <= resid[i][7:0];
        end
    end

    always_comb
    begin
        abs_sum = {2'b00, abs_q[0]} + {2'b00, abs_q[1]}
                + {2'b00, abs_q[2]} + {2'b00, abs_q[3]};
    end

    // clear wins over a pending add
    always_ff @(posedge CLK)
    begin
        if (rst_0 || clear)
            sad <= '0;
        else if (acc_en)
            sad <= sad + {{(SAD_W-10){1'b0}}, abs_sum};
    end

endmodule

// ==== intra4x4_top.sv ====
module intra4x4_top
#(
    parameter int SAD_W = 12
)
(
    input  logic                      CLK,
    input  logic                      rst_0,
    input  logic                      in_strobe,
    input  intra4x4_pkg::row_t        in_row,
    input  intra4x4_pkg::neighbor_t   nbr,
    output logic                      in_ready,
    input  logic                      out_ready,
    output logic                      mode_strobe,
    output intra4x4_pkg::pred_mode_e  mode,
    output logic                      out_strobe,
    output intra4x4_pkg::out_word_t   out_word
);

    import intra4x4_pkg::*;

    logic             capture;
    logic [1:0]       rd_index;
    logic [1:0]       idx_q;
    logic             lane_clear;
    logic             lane_acc_en;
    logic             decide;
    row_t             rd_row;
    neighbor_t        nbr_q;
    pixel_t           dc_value;
    row_t             pred_v;
    row_t             pred_h;
    row_t             pred_dc;
    row_t             base_q;
    resid_row_t       resid_v;
    resid_row_t       resid_h;
    resid_row_t       resid_dc;
    logic [SAD_W-1:0] sad_v;
    logic [SAD_W-1:0] sad_h;
    logic [SAD_W-1:0] sad_dc;

    intra4x4_controller u_ctrl (
        .CLK         (CLK),
        .rst_0       (rst_0),
        .in_strobe   (in_strobe),
        .out_ready   (out_ready),
        .in_ready    (in_ready),
        .capture     (capture),
        .rd_index    (rd_index),
        .lane_clear  (lane_clear),
        .lane_acc_en (lane_acc_en),
        .decide      (decide),
        .mode_strobe (mode_strobe),
        .out_strobe  (out_strobe)
    );

    // strobes outside the load window are dropped
    intra4x4_row_buffer u_buf (
        .CLK       (CLK),
        .rst_0     (rst_0),
        .in_strobe (in_strobe && in_ready),
        .in_row    (in_row),
        .rd_index  (rd_index),
        .rd_row    (rd_row)
    );

    intra4x4_neighbor_unit u_nbr (
        .CLK      (CLK),
        .rst_0    (rst_0),
        .capture  (capture),
        .nbr      (nbr),
        .nbr_q    (nbr_q),
        .dc_value (dc_value)
    );

    // row index lined up with the registered buffer read
    always_ff @(posedge CLK)
    begin
        idx_q <= rd_index;
    end

    assign pred_v  = nbr_q.top;
    assign pred_h  = {4{nbr_q.left[idx_q]}};
    assign pred_dc = {4{dc_value}};

    intra4x4_sad_lane #(.SAD_W(SAD_W)) u_lane_v (
        .CLK    (CLK),
        .rst_0  (rst_0),
        .pixels (rd_row),
        .pred   (pred_v),
        .clear  (lane_clear),
        .acc_en (lane_acc_en),
        .resid  (resid_v),
        .sad    (sad_v)
    );

    intra4x4_sad_lane #(.SAD_W(SAD_W)) u_lane_h (
        .CLK    (CLK),
        .rst_0  (rst_0),
        .pixels (rd_row),
        .pred   (pred_h),
        .clear  (lane_clear),
        .acc_en (lane_acc_en),
        .resid  (resid_h),
        .sad    (sad_h)
    );

    intra4x4_sad_lane #(.SAD_W(SAD_W)) u_lane_dc (
        .CLK    (CLK),
        .rst_0  (rst_0),
        .pixels (rd_row),
        .pred   (pred_dc),
        .clear  (lane_clear),
        .acc_en (lane_acc_en),
        .resid  (resid_dc),
        .sad    (sad_dc)
    );

    intra4x4_mode_select #(.SAD_W(SAD_W)) u_sel (
        .CLK        (CLK),
        .rst_0      (rst_0),
        .decide     (decide),
        .top_valid  (nbr_q.top_valid),
        .left_valid (nbr_q.left_valid),
        .sad_v      (sad_v),
        .sad_h      (sad_h),
        .sad_dc     (sad_dc),
        .mode       (mode)
    );

    // base travels alongside the lane's first stage
    always_ff @(posedge CLK)
    begin
        case (mode)
            mode_vertical:   base_q <= pred_v;
            mode_horizontal: base_q <= pred_h;
            default:         base_q <= pred_dc;
        endcase
    end

    always_comb
    begin
        case (mode)
            mode_vertical:   out_word.resid = resid_v;
            mode_horizontal: out_word.resid = resid_h;
            default:         out_word.resid = resid_dc;
        endcase
        out_word.base = base_q;
    end

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen
#(
    parameter int PERIOD = 8
)
(
    output logic CLK
);

    // half a period per phase
    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

endmodule

// ==== tb_intra4x4.sv ====
module tb_intra4x4;

    import intra4x4_pkg::*;

    localparam int NUM_BLOCKS     = 55;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 60 * NUM_BLOCKS + RESET_CYCLES;

    typedef struct packed {
        pred_mode_e      mode;
        out_word_t [3:0] words;
    } block_exp_t;

    logic       CLK;
    logic       rst_0;
    logic       in_strobe;
    row_t       in_row;
    neighbor_t  nbr;
    logic       in_ready;
    logic       out_ready;
    logic       mode_strobe;
    pred_mode_e mode;
    logic       out_strobe;
    out_word_t  out_word;

    block_exp_t exp_q[$];
    string      name_q[$];
    block_exp_t cur_exp;
    string      cur_name;
    int         cycle = 0;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         blocks_sent = 0;
    int         blocks_done = 0;
    int         modes_seen = 0;
    int         load_cnt = 0;
    int         load_done_cycle = 0;
    int         word_cnt = ROWS;
    logic       prev_os = 1'b0;
    logic       ready_due = 1'b0;

    tb_clock_gen #(.PERIOD(8)) u_clk (.CLK(CLK));

    intra4x4_top #(.SAD_W(12)) UUT (
        .CLK         (CLK),
        .rst_0       (rst_0),
        .in_strobe   (in_strobe),
        .in_row      (in_row),
        .nbr         (nbr),
        .in_ready    (in_ready),
        .out_ready   (out_ready),
        .mode_strobe (mode_strobe),
        .mode        (mode),
        .out_strobe  (out_strobe),
        .out_word    (out_word)
    );

    task automatic check(input string test, input string what,
                         input logic [71:0] expected, input logic [71:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("CHECK FAILED %s: %s expected %0h actual %0h",
                     test, what, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    function automatic int absdiff(input pixel_t a, input pixel_t b);
        int d;
        d = int'(a) - int'(b);
        return (d < 0) ? -d : d;
    endfunction

    // expected mode, residual rows and bases straight from the prediction rules
    function automatic block_exp_t ref_block(input row_t [3:0] blk, input neighbor_t n);
        block_exp_t res;
        row_t [3:0] pv;
        row_t [3:0] ph;
        row_t [3:0] pd;
        row_t [3:0] pb;
        pixel_t     dc;
        int         st;
        int         sl;
        int         sv;
        int         sh;
        int         sdc;
        int         best;
        int         k;
        logic [1:0] r;
        logic [1:0] i;
        st = int'(n.top[0]) + int'(n.top[1]) + int'(n.top[2]) + int'(n.top[3]);
        sl = int'(n.left[0]) + int'(n.left[1]) + int'(n.left[2]) + int'(n.left[3]);
        if (n.top_valid && n.left_valid)
            dc = pixel_t'((st + sl + 4) >> 3);
        else if (n.top_valid)
            dc = pixel_t'((2 * st + 4) >> 3);
        else if (n.left_valid)
            dc = pixel_t'((2 * sl + 4) >> 3);
        else
            dc = DC_DEFAULT;
        sv  = 0;
        sh  = 0;
        sdc = 0;
        for (k = 0; k < 16; k++)
        begin
            r = 2'(k >> 2);
            i = 2'(k);
            pv[r] = n.top;
            ph[r] = {4{n.left[r]}};
            pd[r] = {4{dc}};
            sv  += absdiff(blk[r][i], pv[r][i]);
            sh  += absdiff(blk[r][i], ph[r][i]);
            sdc += absdiff(blk[r][i], pd[r][i]);
        end
        // strict compares keep the earlier mode on a tie
        best     = 1 << 30;
        res.mode = mode_dc;
        pb       = pd;
        if (n.top_valid)
        begin
            best     = sv;
            res.mode = mode_vertical;
            pb       = pv;
        end
        if (n.left_valid && sh < best)
        begin
            best     = sh;
            res.mode = mode_horizontal;
            pb       = ph;
        end
        if (sdc < best)
        begin
            res.mode = mode_dc;
            pb       = pd;
        end
        for (k = 0; k < 16; k++)
        begin
            r = 2'(k >> 2);
            i = 2'(k);
            res.words[r].resid[i] = resid_t'(int'(blk[r][i]) - int'(pb[r][i]));
            res.words[r].base     = pb[r];
        end
        return res;
    endfunction

    function automatic row_t rand_row();
        return row_t'($urandom);
    endfunction

    function automatic neighbor_t rand_nbr();
        neighbor_t n;
        n.top        = rand_row();
        n.left       = rand_row();
        n.top_valid  = 1'($urandom);
        n.left_valid = 1'($urandom);
        return n;
    endfunction

    // one block with optional idle gaps between rows and a hold on out_ready
    task automatic send_block(input string name, input row_t [3:0] blk, input neighbor_t n,
                              input int gap, input int hold);
        int target;
        int r;
        target      = blocks_sent + 1;
        blocks_sent = target;
        exp_q.push_back(ref_block(blk, n));
        name_q.push_back(name);
        out_ready = (hold == 0);
        for (r = 0; r < ROWS; r++)
        begin
            if (r > 0)
            begin
                repeat (gap)
                begin
                    @(posedge CLK);
                    #1;
                end
            end
            while (!in_ready)
            begin
                @(posedge CLK);
                #1;
            end
            in_strobe = 1'b1;
            in_row    = blk[2'(r)];
            if (r == 0)
                nbr = n;
            @(posedge CLK);
            #1;
            in_strobe = 1'b0;
            // only the first strobe's neighbors count
            nbr = ~n;
        end
        if (hold > 0)
        begin
            while (modes_seen < target)
            begin
                @(posedge CLK);
                #1;
            end
            repeat (hold)
            begin
                check(name, "out_strobe while held", 72'(0), 72'(out_strobe));
                check(name, "in_ready while held", 72'(0), 72'(in_ready));
                @(posedge CLK);
                #1;
            end
            out_ready = 1'b1;
        end
        while (blocks_done < target)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests++;
        $display("test %-13s %0d errors", name, errors - err_before);
    endtask

    initial
    begin
        row_t [3:0] blk;
        neighbor_t  n;
        int         e0;
        int         f;
        void'($urandom(32'h55f32a11));
        rst_0     = 1'b1;
        in_strobe = 1'b0;
        in_row    = '0;
        nbr       = '0;
        out_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        rst_0 = 1'b0;

        e0 = errors;
        repeat (4)
        begin
            @(posedge CLK);
            #1;
            check("reset", "in_ready", 72'(1), 72'(in_ready));
            check("reset", "mode_strobe", 72'(0), 72'(mode_strobe));
            check("reset", "out_strobe", 72'(0), 72'(out_strobe));
        end
        finish_test("reset", e0);

        e0 = errors;
        n.top        = {8'd200, 8'd17, 8'd90, 8'd45};
        n.left       = {8'd3, 8'd250, 8'd128, 8'd64};
        n.top_valid  = 1'b1;
        n.left_valid = 1'b1;
        blk = {4{n.top}};
        send_block("vertical", blk, n, 0, 0);
        blk = {{4{n.left[3]}}, {4{n.left[2]}}, {4{n.left[1]}}, {4{n.left[0]}}};
        send_block("horizontal", blk, n, 0, 0);
        finish_test("vert_horiz", e0);

        // flat block under all four flag combinations
        e0 = errors;
        blk = {16{8'd77}};
        for (f = 0; f < 4; f++)
        begin
            // a neighbor whose flag is clear matches the block exactly
            n.top        = f[1] ? {8'd200, 8'd17, 8'd90, 8'd45} : {4{8'd77}};
            n.left       = f[0] ? {8'd3, 8'd250, 8'd128, 8'd64} : {4{8'd77}};
            n.top_valid  = f[1];
            n.left_valid = f[0];
            send_block("dc_flags", blk, n, 0, 0);
        end
        finish_test("dc_flags", e0);

        e0 = errors;
        repeat (40)
        begin
            blk = {rand_row(), rand_row(), rand_row(), rand_row()};
            send_block("random", blk, rand_nbr(), 0, 0);
        end
        finish_test("random", e0);

        e0 = errors;
        repeat (4)
        begin
            blk = {rand_row(), rand_row(), rand_row(), rand_row()};
            send_block("backpressure", blk, rand_nbr(), 0, $urandom_range(20, 1));
        end
        finish_test("backpressure", e0);

        // equal predictions force equal sads
        e0 = errors;
        n.top        = {4{8'd50}};
        n.left       = {4{8'd50}};
        n.top_valid  = 1'b1;
        n.left_valid = 1'b1;
        blk = {rand_row(), rand_row(), rand_row(), rand_row()};
        send_block("tie_all", blk, n, 0, 0);
        n.top_valid = 1'b0;
        send_block("tie_h_dc", blk, n, 0, 0);
        n.top        = {4{8'd90}};
        n.top_valid  = 1'b1;
        n.left_valid = 1'b0;
        send_block("tie_v_dc", blk, n, 0, 0);
        blk = {rand_row(), rand_row(), rand_row(), rand_row()};
        n   = rand_nbr();
        send_block("gaps", blk, n, 0, 0);
        send_block("gaps", blk, n, 3, 0);
        finish_test("ties_gaps", e0);

        $display("%0d tests, %0d blocks, %0d checks, %0d errors",
                 tests, blocks_done, checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // outputs sampled at the falling edge away from DUT updates
    always @(negedge CLK)
    begin
        if (!rst_0)
        begin
            if (ready_due)
            begin
                check(cur_name, "in_ready after burst", 72'(1), 72'(in_ready));
                ready_due = 1'b0;
            end
            if (in_strobe && in_ready)
            begin
                load_cnt++;
                if (load_cnt == ROWS)
                begin
                    load_cnt        = 0;
                    load_done_cycle = cycle;
                end
            end
            if (mode_strobe)
            begin
                if (exp_q.size() == 0)
                    report_error("mode_strobe seen with no block pending");
                else
                begin
                    cur_exp  = exp_q.pop_front();
                    cur_name = name_q.pop_front();
                    modes_seen++;
                    word_cnt = 0;
                    check(cur_name, "mode", 72'(cur_exp.mode), 72'(mode));
                    // four reads and five more cycles
                    check(cur_name, "mode latency", 72'(9), 72'(cycle - load_done_cycle));
                end
            end
            if (out_strobe)
            begin
                if (word_cnt >= ROWS)
                    report_error("out_strobe seen outside an output burst");
                else
                begin
                    if (word_cnt > 0)
                        check(cur_name, "burst continuity", 72'(1), 72'(prev_os));
                    check(cur_name, $sformatf("resid row %0d", word_cnt),
                          72'(cur_exp.words[2'(word_cnt)].resid), 72'(out_word.resid));
                    check(cur_name, $sformatf("base row %0d", word_cnt),
                          72'(cur_exp.words[2'(word_cnt)].base), 72'(out_word.base));
                    word_cnt++;
                    if (word_cnt == ROWS)
                    begin
                        blocks_done++;
                        ready_due = 1'b1;
                    end
                end
            end
            prev_os = out_strobe;
        end
    end

    always @(posedge CLK)
    begin
        cycle++;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run stopped after %0d cycles", cycle);
            $display("tests failed");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
intra4x4_pkg.sv
intra4x4_row_buffer.sv
intra4x4_neighbor_unit.sv
intra4x4_sad_lane.sv
intra4x4_mode_select.sv
intra4x4_controller.sv
intra4x4_top.sv
tb_clock_gen.sv
tb_intra4x4.sv
